//--- axis_if.sv
// valid/ready stream bundle with master and slave modports, used between internal blocks
`timescale 1ns/1ps
`default_nettype none

interface axis_if;

    logic                  tvalid;
    logic                  tready;
    wfd_pkg::stream_word_t tdata;
    logic                  tlast;   // final word of a packet
    wfd_pkg::chan_id_t     tdest;   // channel the word goes to or came from

    modport master (output tvalid, tdata, tlast, tdest, input tready);
    modport slave  (input tvalid, tdata, tlast, tdest, output tready);

endinterface

`default_nettype wire

//--- daq_pkg.sv
// DAQ event word format, channel command opcodes and readout FSM states, imported where needed
`default_nettype none

package daq_pkg;

    localparam int daq_data_w = 64;  // width of the DAQ link word

    typedef logic [daq_data_w-1:0] daq_word_t;

    localparam logic [7:0] daq_header_tag = 8'ha5;  // top byte of every header word

    // command opcode lives in bits 31:24 of a command word
    typedef enum logic [7:0] {
        cmd_readout = 8'h01   // fill number in bits 23:0
    } chan_cmd_e;

    // readout manager FSM
    typedef enum logic [2:0] {
        idle,      // waiting on a queued fill number
        header,    // header word on the DAQ link
        send_cmd,  // readout command to the current channel
        gather,    // forward channel words until tlast
        trailer    // closing word with the count
    } readout_state_e;

endpackage

`default_nettype wire

//--- fill_num_fifo.sv
// small synchronous FIFO of fill numbers between the trigger manager and the readout manager
`timescale 1ns/1ps
`default_nettype none

module fill_num_fifo
    import wfd_pkg::*;
(
    input  wire        clk125,
    input  wire        rst_n,
    input  wire        push,
    input  fill_num_t  push_data,
    output logic       full,
    input  wire        pop,
    output fill_num_t  pop_data,   // head entry, valid while not empty
    output logic       empty
);

    fill_num_t                            mem [fill_fifo_depth];
    logic [$clog2(fill_fifo_depth)-1:0]   wr_ptr;
    logic [$clog2(fill_fifo_depth)-1:0]   rd_ptr;
    logic [$clog2(fill_fifo_depth+1)-1:0] count;  // entries held
    logic                                 do_push;
    logic                                 do_pop;

    assign full     = (count == fill_fifo_depth);
    assign empty    = (count == '0);
    assign do_push  = push && !full;   // push into a full FIFO is dropped
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk125) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk125) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- readout_manager.sv
// per-fill readout: commands each channel, gathers its packet and frames one DAQ event
`timescale 1ns/1ps
`default_nettype none

module readout_manager
    import wfd_pkg::*;
    import daq_pkg::*;
(
    input  wire           clk125,
    input  wire           rst_n,
    input  wire           fifo_empty,
    output logic          fifo_pop,
    input  fill_num_t     fill_num,     // head of the fill FIFO
    axis_if.master        cmd_out,      // readout commands toward the tx router
    axis_if.slave         rx_in,        // merged channel data
    output logic          daq_valid,
    output logic          daq_header,
    output logic          daq_trailer,
    output daq_word_t     daq_data,
    input  wire           daq_ready
);

    readout_state_e state;
    fill_num_t      fill_reg;   // fill being read out
    chan_id_t       chan_sel;   // channel being served
    logic [23:0]    word_cnt;   // payload words in this event
    logic           rx_beat;
    logic           last_chan;

    assign fifo_pop  = (state == idle) && !fifo_empty;
    assign rx_beat   = (state == gather) && rx_in.tvalid && daq_ready;
    assign last_chan = (chan_sel == chan_id_t'(num_chan - 1));

    // one-word command per channel
    assign cmd_out.tvalid = (state == send_cmd);
    assign cmd_out.tdata  = {cmd_readout, fill_reg};
    assign cmd_out.tlast  = 1'b1;
    assign cmd_out.tdest  = chan_sel;

    // channel words go straight through, so DAQ back-pressure reaches the channels
    assign rx_in.tready = (state == gather) && daq_ready;

    assign daq_header  = (state == header);
    assign daq_trailer = (state == trailer);
    assign daq_valid   = daq_header || daq_trailer || ((state == gather) && rx_in.tvalid);

    always_comb begin
        case (state)
            header:  daq_data = {daq_header_tag, 32'h0, fill_reg};
            trailer: daq_data = {8'h00, word_cnt, 8'h00, fill_reg};  // count in 55:32
            gather:  daq_data = {{(8-chan_id_w){1'b0}}, rx_in.tdest, 24'h0, rx_in.tdata};
            default: daq_data = '0;
        endcase
    end

    always_ff @(posedge clk125) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle: if (!fifo_empty) state <= header;
                header: if (daq_ready) state <= send_cmd;
                send_cmd: if (cmd_out.tready) state <= gather;
                gather: begin
                    if (rx_beat && rx_in.tlast) begin
                        state <= last_chan ? trailer : send_cmd;  // next channel or close
                    end
                end
                trailer: if (daq_ready) state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // event bookkeeping
    always_ff @(posedge clk125) begin
        if (fifo_pop) begin
            fill_reg <= fill_num;  // capture head as it is popped
            chan_sel <= '0;
            word_cnt <= '0;
        end else begin
            if (rx_beat) word_cnt <= word_cnt + 1'b1;
            if (rx_beat && rx_in.tlast && !last_chan) chan_sel <= chan_sel + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log for the fail message
verilator --binary --timing -Wno-fatal --top-module tb_wfd_master -f wfd_master.f -o sim_wfd \
    > build.log 2>&1 && ./obj_dir/sim_wfd > sim.log 2>&1 || { cat build.log sim.log; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0

//--- rx_arbiter.sv
// round-robin merge of the channel receive streams, locked to a packet until its tlast
`timescale 1ns/1ps
`default_nettype none

module rx_arbiter
    import wfd_pkg::*;
(
    input  wire                        clk125,
    input  wire                        rst_n,
    input  wire   [num_chan-1:0]       chan_rx_tvalid,
    input  stream_word_t [num_chan-1:0] chan_rx_tdata,
    input  wire   [num_chan-1:0]       chan_rx_tlast,
    output logic  [num_chan-1:0]       chan_rx_tready,
    axis_if.master                     merged
);

    chan_id_t grant;    // channel of the current or last packet
    logic     busy;     // packet in progress, grant locked
    chan_id_t nxt;      // round-robin candidate
    chan_id_t sel;      // channel passed through this cycle

    assign nxt = grant + chan_id_t'(1);

    // locked grant wins, otherwise the other channel gets first pick
    assign sel = busy ? grant : (chan_rx_tvalid[nxt] ? nxt : grant);

    assign merged.tvalid = chan_rx_tvalid[sel];
    assign merged.tdata  = chan_rx_tdata[sel];
    assign merged.tlast  = chan_rx_tlast[sel];
    assign merged.tdest  = sel;  // tags the source channel

    always_comb begin
        chan_rx_tready = '0;
        chan_rx_tready[sel] = merged.tready;
    end

    always_ff @(posedge clk125) begin
        if (!rst_n) begin
            grant <= chan_id_t'(num_chan - 1);  // channel 0 gets first pick
            busy  <= 1'b0;
        end else if (merged.tvalid) begin
            grant <= sel;
            busy  <= !(merged.tready && merged.tlast);  // release on accepted tlast
        end
    end

endmodule

`default_nettype wire

//--- tb_wfd_master.sv
// simulation top for the master board data path with channel models, host traffic and scoreboard
`timescale 1ns/1ps
`default_nettype none

module tb_wfd_master
    import wfd_pkg::*;
    import daq_pkg::*;
();

    localparam int n_rand_trig = 40;               // trigger attempts in the random test
    localparam int n_trig      = n_rand_trig + 4;  // plus the burst

    logic                         clk125 = 1'b0;
    logic                         rst_n;
    logic                         trigger;
    logic [num_chan-1:0]          chan_done;
    logic [num_chan-1:0]          acq_trigs;
    logic                         host_tvalid;
    stream_word_t                 host_tdata;
    chan_id_t                     host_tdest;
    logic                         host_tlast;
    logic                         host_tready;
    logic [num_chan-1:0]          chan_tx_tvalid;
    stream_word_t [num_chan-1:0]  chan_tx_tdata;
    logic [num_chan-1:0]          chan_tx_tlast;
    logic [num_chan-1:0]          chan_tx_tready;
    logic [num_chan-1:0]          chan_rx_tvalid;
    stream_word_t [num_chan-1:0]  chan_rx_tdata;
    logic [num_chan-1:0]          chan_rx_tlast;
    logic [num_chan-1:0]          chan_rx_tready;
    logic                         daq_valid;
    logic                         daq_header;
    logic                         daq_trailer;
    daq_word_t                    daq_data;
    logic                         daq_ready;

    int seed = 73316;
    int errors = 0;
    int tests = 0;
    int failed = 0;
    int accepted = 0;   // triggers the model accepted
    int completed = 0;  // trailers seen
    int dropped = 0;

    // scoreboard state
    logic [num_chan-1:0] mask_m;    // model of the done mask
    logic                acc_prev;  // accept one cycle ago so a go pulse is due now
    logic                acc;
    fill_num_t           fill_q [$];           // fills waiting for their DAQ event
    fill_num_t           cmd_q [num_chan][$];  // readout commands each channel still expects
    stream_word_t        pay_q [num_chan][$];  // payload words expected on the DAQ link
    int                  len_q [num_chan][$];  // packet length per readout
    logic [32:0]         host_q [num_chan][$]; // {tlast, word} sent by the host
    logic                host_open [num_chan]; // host packet in progress on the link
    int                  ec;                   // channel expected in the event
    int                  rem;                  // words left in its packet
    int                  cnt;                  // payload words so far
    stream_word_t        w;
    int                  n;

    // channel and host model state
    stream_word_t        rx_q [num_chan][$];
    int                  rx_delay [num_chan];
    int                  done_timer [num_chan];
    logic                rx_acc [num_chan];
    logic                host_acc;
    logic                host_en;
    logic                hold_daq;
    int                  host_left;
    chan_id_t            host_dst;

    wfd_master i_wfd_master (
        .clk125(clk125), .rst_n(rst_n), .trigger(trigger), .chan_done(chan_done),
        .acq_trigs(acq_trigs), .host_tvalid(host_tvalid), .host_tdata(host_tdata),
        .host_tdest(host_tdest), .host_tlast(host_tlast), .host_tready(host_tready),
        .chan_tx_tvalid(chan_tx_tvalid), .chan_tx_tdata(chan_tx_tdata),
        .chan_tx_tlast(chan_tx_tlast), .chan_tx_tready(chan_tx_tready),
        .chan_rx_tvalid(chan_rx_tvalid), .chan_rx_tdata(chan_rx_tdata),
        .chan_rx_tlast(chan_rx_tlast), .chan_rx_tready(chan_rx_tready),
        .daq_valid(daq_valid), .daq_header(daq_header), .daq_trailer(daq_trailer),
        .daq_data(daq_data), .daq_ready(daq_ready)
    );

    always #4 clk125 = ~clk125;  // 8 ns period

    function automatic int rand_range(input int lo, input int hi);
        int v;
        v = $random(seed);
        v = v & 32'h7fff_ffff;
        return lo + v % (hi - lo + 1);
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic complain(input string what);
        errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    // one readout or host word arriving on channel c's command link
    task automatic receive_cmd(input int c);
        w = chan_tx_tdata[c];
        if (w[31:24] == cmd_readout) begin
            if (host_open[c]) complain("readout command inside a host packet");
            check("chan_tx_tlast", chan_tx_tlast[c], 1'b1);
            if (cmd_q[c].size() == 0) begin
                complain("readout command that no trigger asked for");
            end else begin
                check("chan_tx_tdata", w[23:0], cmd_q[c].pop_front());
            end
            n = rand_range(1, 4);  // packet answered after a random delay
            for (int i = 0; i < n; i++) begin
                rx_q[c].push_back(stream_word_t'($random(seed)));
                pay_q[c].push_back(rx_q[c][rx_q[c].size() - 1]);
            end
            len_q[c].push_back(n);
            rx_delay[c] = rand_range(1, 10);
        end else if (host_q[c].size() == 0) begin
            complain("host word on a channel that was not addressed");
        end else begin
            check("{chan_tx_tlast, chan_tx_tdata}", {chan_tx_tlast[c], w},
                  host_q[c].pop_front());
            host_open[c] = !chan_tx_tlast[c];
        end
    endtask

    // one accepted DAQ word against the event rules
    task automatic check_daq();
        if (daq_header) begin
            if (fill_q.size() == 0) complain("DAQ header with no accepted trigger");
            else check("daq_data", daq_data, {daq_header_tag, 32'h0, fill_q[0]});
            ec = 0;
            rem = 0;
            cnt = 0;
        end else if (daq_trailer) begin
            if (ec != 1 || rem != 0) complain("trailer before both channel packets ended");
            if (fill_q.size() != 0) begin
                check("daq_data", daq_data, {8'h00, cnt[23:0], 8'h00, fill_q.pop_front()});
            end
            completed++;
        end else begin
            if (rem == 0) begin
                if (len_q[ec].size() == 0) begin
                    complain("DAQ data word with no pending channel packet");
                    return;
                end
                rem = len_q[ec].pop_front();
            end
            check("daq_data", daq_data, {7'h0, ec[0], 24'h0, pay_q[ec].pop_front()});
            rem--;
            cnt++;
            if (rem == 0 && ec == 0) ec = 1;  // channel 1 follows
        end
    endtask

    // sample at the falling edge and drive 1 ns after the rising edge
    always begin
        @(negedge clk125);
        if (!rst_n) begin
            mask_m   = '1;
            acc_prev = 1'b0;
            host_acc = 1'b0;
            for (int c = 0; c < num_chan; c++) rx_acc[c] = 1'b0;
        end else begin
            acc = trigger && (&mask_m);
            check("acq_trigs", acq_trigs, {num_chan{acc_prev}});
            if (trigger && !acc) dropped++;
            if (acc) begin
                accepted++;
                fill_q.push_back(fill_num_t'(accepted));
                for (int c = 0; c < num_chan; c++) cmd_q[c].push_back(fill_num_t'(accepted));
                mask_m = '0;
            end else begin
                mask_m = mask_m | chan_done;
            end
            acc_prev = acc;
            host_acc = host_tvalid && host_tready;
            if (host_acc) host_q[host_tdest].push_back({host_tlast, host_tdata});
            for (int c = 0; c < num_chan; c++) begin
                if (acq_trigs[c]) done_timer[c] = rand_range(2, 20);
                if (chan_tx_tvalid[c] && chan_tx_tready[c]) receive_cmd(c);
                rx_acc[c] = chan_rx_tvalid[c] && chan_rx_tready[c];
            end
            if (daq_valid && daq_ready) check_daq();
        end
        @(posedge clk125);
        #1;
        daq_ready = hold_daq ? 1'b0 : (rand_range(0, 3) != 0);
        chan_done = '0;
        for (int c = 0; c < num_chan; c++) begin
            chan_tx_tready[c] = (rand_range(0, 3) != 0);
            if (done_timer[c] > 0) begin
                done_timer[c]--;
                if (done_timer[c] == 0) chan_done[c] = 1'b1;
            end
            if (rx_acc[c]) void'(rx_q[c].pop_front());
            chan_rx_tvalid[c] = 1'b0;
            if (rx_q[c].size() != 0) begin
                if (rx_delay[c] > 0) begin
                    rx_delay[c]--;
                end else begin
                    chan_rx_tvalid[c] = 1'b1;  // held until accepted
                    chan_rx_tdata[c]  = rx_q[c][0];
                    chan_rx_tlast[c]  = (rx_q[c].size() == 1);
                end
            end
        end
        if (host_acc) begin
            host_left--;
            host_tvalid = 1'b0;
        end
        if (host_left == 0 && host_en && rand_range(0, 7) == 0) begin
            host_left = rand_range(1, 3);
            host_dst  = chan_id_t'(rand_range(0, 1));
        end
        if (host_left > 0 && !host_tvalid) begin
            host_tvalid = 1'b1;
            host_tdata  = {1'b1, 31'($random(seed))};  // top byte never a readout opcode
            host_tdest  = host_dst;
            host_tlast  = (host_left == 1);
        end
    end

    task automatic pulse_trigger();
        @(posedge clk125);
        #1;
        trigger = 1'b1;
        @(posedge clk125);
        #1;
        trigger = 1'b0;
    endtask

    task automatic wait_drain();
        while (completed != accepted) @(posedge clk125);
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic check_idle_outputs();
        check("acq_trigs", acq_trigs, '0);
        check("daq_valid", daq_valid, 1'b0);
        check("chan_tx_tvalid", chan_tx_tvalid, '0);
        check("chan_rx_tready", chan_rx_tready, '0);
    endtask

    initial begin
        int e0;
        rst_n = 1'b0;
        trigger = 1'b0;
        chan_done = '0;
        host_tvalid = 1'b0;
        host_tdata = '0;
        host_tdest = '0;
        host_tlast = 1'b0;
        chan_tx_tready = '0;
        chan_rx_tvalid = '0;
        chan_rx_tdata = '0;
        chan_rx_tlast = '0;
        daq_ready = 1'b0;
        host_en = 1'b0;
        hold_daq = 1'b0;
        host_left = 0;
        for (int c = 0; c < num_chan; c++) begin
            rx_delay[c] = 0;
            done_timer[c] = 0;
            host_open[c] = 1'b0;
        end

        e0 = errors;
        repeat (4) begin
            @(negedge clk125);
            check_idle_outputs();
        end
        @(posedge clk125);
        #1;
        rst_n = 1'b1;
        repeat (2) begin
            @(negedge clk125);
            check_idle_outputs();
        end
        report_test("reset outputs", e0);

        // random triggers with some dropped while channels are still busy
        e0 = errors;
        host_en = 1'b1;
        for (int i = 0; i < n_rand_trig; i++) begin
            repeat (rand_range(0, 25)) @(posedge clk125);
            while (accepted - completed >= fill_fifo_depth) @(posedge clk125);
            pulse_trigger();
        end
        wait_drain();
        $display("random triggers: %0d accepted, %0d dropped", accepted, dropped);
        report_test("random triggers and readout", e0);

        e0 = errors;
        repeat (300) @(posedge clk125);
        host_en = 1'b0;
        while (host_tvalid || host_left != 0) @(posedge clk125);
        repeat (4) @(negedge clk125);
        for (int c = 0; c < num_chan; c++) begin
            if (host_q[c].size() != 0) complain("host words never reached their channel");
        end
        report_test("host traffic", e0);

        // burst with the DAQ link stalled so fills pile up in the FIFO
        e0 = errors;
        hold_daq = 1'b1;
        while (accepted - completed < fill_fifo_depth) begin
            if (&mask_m) pulse_trigger();
            else @(posedge clk125);
        end
        repeat (50) @(posedge clk125);
        @(negedge clk125);
        // oldest fill's header held on the link while the channels see no tready
        check("daq_valid", daq_valid, 1'b1);
        check("daq_header", daq_header, 1'b1);
        check("daq_data", daq_data, {daq_header_tag, 32'h0, fill_q[0]});
        check("chan_rx_tready", chan_rx_tready, '0);
        hold_daq = 1'b0;
        wait_drain();
        report_test("queued fills under held daq_ready", e0);

        repeat (10) @(posedge clk125);
        $display("tests %0d, failed %0d, check errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog sized from the number of triggers
    initial begin
        repeat (n_trig * 400 + 2000) @(posedge clk125);
        $display("timeout: the tests did not finish in the allowed number of cycles");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- trigger_manager.sv
// trigger handling: gates triggers on channel done, pulses the go lines and queues a fill number
`timescale 1ns/1ps
`default_nettype none

module trigger_manager
    import wfd_pkg::*;
(
    input  wire                 clk125,
    input  wire                 rst_n,
    input  wire                 trigger,      // raw trigger request
    input  wire  [num_chan-1:0] chan_done,    // done pulses back from the channels
    input  wire                 fifo_full,
    output logic                fifo_push,
    output fill_num_t           fill_num,     // value pushed with fifo_push
    output logic [num_chan-1:0] acq_trigs     // go pulse to every channel
);

    fill_num_t           fill_cnt;   // last fill number handed out
    logic [num_chan-1:0] done_mask;  // done pulses seen since the last go
    logic                accept;

    // all channels finished and room for another fill
    assign accept    = trigger && (&done_mask) && !fifo_full;
    assign fifo_push = accept;
    assign fill_num  = fill_cnt + fill_num_t'(1);  // first fill after reset is 1

    always_ff @(posedge clk125) begin
        if (!rst_n) begin
            fill_cnt  <= '0;
            done_mask <= '1;  // channels start out idle
            acq_trigs <= '0;
        end else begin
            acq_trigs <= {num_chan{accept}};  // single cycle, one after the trigger
            if (accept) begin
                fill_cnt  <= fill_num;
                done_mask <= '0;  // wait for every channel again
            end else begin
                done_mask <= done_mask | chan_done;
            end
        end
    end

endmodule

`default_nettype wire

//--- tx_router.sv
// shares the channel command links between host and readout commands, routed by tdest
`timescale 1ns/1ps
`default_nettype none

module tx_router
    import wfd_pkg::*;
(
    input  wire                         clk125,
    input  wire                         rst_n,
    axis_if.slave                       host_in,
    axis_if.slave                       readout_in,
    output logic  [num_chan-1:0]        chan_tx_tvalid,
    output stream_word_t [num_chan-1:0] chan_tx_tdata,
    output logic  [num_chan-1:0]        chan_tx_tlast,
    input  wire   [num_chan-1:0]        chan_tx_tready
);

    logic         grant;      // 0 host, 1 readout
    logic         busy;       // packet in progress
    logic         sel;        // source passed through this cycle
    logic         sel_valid;
    stream_word_t sel_data;
    logic         sel_last;
    chan_id_t     sel_dest;
    logic         sel_ready;  // ready of the addressed channel

    // stay on a locked source, else prefer the one not served last
    always_comb begin
        if (busy) begin
            sel = grant;
        end else if (grant) begin
            sel = host_in.tvalid ? 1'b0 : 1'b1;
        end else begin
            sel = readout_in.tvalid ? 1'b1 : 1'b0;
        end
    end

    assign sel_valid = sel ? readout_in.tvalid : host_in.tvalid;
    assign sel_data  = sel ? readout_in.tdata  : host_in.tdata;
    assign sel_last  = sel ? readout_in.tlast  : host_in.tlast;
    assign sel_dest  = sel ? readout_in.tdest  : host_in.tdest;
    assign sel_ready = chan_tx_tready[sel_dest];

    assign host_in.tready    = sel_ready && !sel;
    assign readout_in.tready = sel_ready && sel;

    // data and last fan out, valid only to the addressed channel
    always_comb begin
        chan_tx_tvalid = '0;
        chan_tx_tvalid[sel_dest] = sel_valid;
        chan_tx_tdata = {num_chan{sel_data}};
        chan_tx_tlast = {num_chan{sel_last}};
    end

    always_ff @(posedge clk125) begin
        if (!rst_n) begin
            grant <= 1'b1;  // host gets first pick
            busy  <= 1'b0;
        end else if (sel_valid) begin
            grant <= sel;
            busy  <= !(sel_ready && sel_last);  // unlock after the last word goes
        end
    end

endmodule

`default_nettype wire

//--- wfd_master.f
wfd_pkg.sv
daq_pkg.sv
axis_if.sv
trigger_manager.sv
fill_num_fifo.sv
readout_manager.sv
rx_arbiter.sv
tx_router.sv
wfd_master.sv
tb_wfd_master.sv

//--- wfd_master.sv
// master board data path top: trigger, fill queue, readout and the two link arbiters
`timescale 1ns/1ps
`default_nettype none

module wfd_master
    import wfd_pkg::*;
    import daq_pkg::*;
(
    input  wire                         clk125,
    input  wire                         rst_n,
    input  wire                         trigger,
    input  wire   [num_chan-1:0]        chan_done,
    output logic  [num_chan-1:0]        acq_trigs,
    input  wire                         host_tvalid,     // host command stream
    input  stream_word_t                host_tdata,
    input  chan_id_t                    host_tdest,
    input  wire                         host_tlast,
    output logic                        host_tready,
    output logic  [num_chan-1:0]        chan_tx_tvalid,  // command links to the channels
    output stream_word_t [num_chan-1:0] chan_tx_tdata,
    output logic  [num_chan-1:0]        chan_tx_tlast,
    input  wire   [num_chan-1:0]        chan_tx_tready,
    input  wire   [num_chan-1:0]        chan_rx_tvalid,  // data links from the channels
    input  stream_word_t [num_chan-1:0] chan_rx_tdata,
    input  wire   [num_chan-1:0]        chan_rx_tlast,
    output logic  [num_chan-1:0]        chan_rx_tready,
    output logic                        daq_valid,       // DAQ event stream
    output logic                        daq_header,
    output logic                        daq_trailer,
    output daq_word_t                   daq_data,
    input  wire                         daq_ready
);

    logic      fifo_push;
    logic      fifo_pop;
    logic      fifo_full;
    logic      fifo_empty;
    fill_num_t tm_fill_num;    // trigger manager to FIFO
    fill_num_t head_fill_num;  // FIFO to readout manager

    axis_if rx_merged ();
    axis_if readout_cmd ();
    axis_if host_cmd ();

    assign host_cmd.tvalid = host_tvalid;
    assign host_cmd.tdata  = host_tdata;
    assign host_cmd.tdest  = host_tdest;
    assign host_cmd.tlast  = host_tlast;
    assign host_tready     = host_cmd.tready;

    trigger_manager i_trigger_manager (
        .clk125(clk125), .rst_n(rst_n), .trigger(trigger), .chan_done(chan_done),
        .fifo_full(fifo_full), .fifo_push(fifo_push), .fill_num(tm_fill_num),
        .acq_trigs(acq_trigs)
    );

    fill_num_fifo i_fill_num_fifo (
        .clk125(clk125), .rst_n(rst_n), .push(fifo_push), .push_data(tm_fill_num),
        .full(fifo_full), .pop(fifo_pop), .pop_data(head_fill_num), .empty(fifo_empty)
    );

    readout_manager i_readout_manager (
        .clk125(clk125), .rst_n(rst_n), .fifo_empty(fifo_empty), .fifo_pop(fifo_pop),
        .fill_num(head_fill_num), .cmd_out(readout_cmd.master), .rx_in(rx_merged.slave),
        .daq_valid(daq_valid), .daq_header(daq_header), .daq_trailer(daq_trailer),
        .daq_data(daq_data), .daq_ready(daq_ready)
    );

    rx_arbiter i_rx_arbiter (
        .clk125(clk125), .rst_n(rst_n), .chan_rx_tvalid(chan_rx_tvalid),
        .chan_rx_tdata(chan_rx_tdata), .chan_rx_tlast(chan_rx_tlast),
        .chan_rx_tready(chan_rx_tready), .merged(rx_merged.master)
    );

    tx_router i_tx_router (
        .clk125(clk125), .rst_n(rst_n), .host_in(host_cmd.slave),
        .readout_in(readout_cmd.slave), .chan_tx_tvalid(chan_tx_tvalid),
        .chan_tx_tdata(chan_tx_tdata), .chan_tx_tlast(chan_tx_tlast),
        .chan_tx_tready(chan_tx_tready)
    );

endmodule

`default_nettype wire

//--- wfd_pkg.sv
// shared widths, channel count, fill FIFO depth and stream word types, imported by the RTL modules
`default_nettype none

package wfd_pkg;

    localparam int num_chan        = 2;   // channel FPGAs on the board
    localparam int chan_id_w       = 1;   // enough bits to index num_chan
    localparam int stream_data_w   = 32;  // channel link word
    localparam int fill_num_w      = 24;  // fill counter width
    localparam int fill_fifo_depth = 4;   // power of two, pointers wrap on their own

    // channel index, also used as stream tdest
    typedef logic [chan_id_w-1:0] chan_id_t;

    // one word on a channel link
    typedef logic [stream_data_w-1:0] stream_word_t;

    typedef logic [fill_num_w-1:0] fill_num_t;  // fill number as carried to the readout side

endpackage

`default_nettype wire
